// ==== common/pianoParams.svh ====
`ifndef PIANO_PARAMS_SVH
`define PIANO_PARAMS_SVH

// plotter field size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// column geometry
// column c starts at BORDER_W + c * (COL_W + BORDER_W)
`define COL_W 35
`define BORDER_W 4

// full height of a falling tile
`define TILE_H 40

// bottom row at or below this line counts as a hit
`define HIT_LINE 100

// clock cycles between tile steps
`define SHIFT_PERIOD 160

// clock cycles between spawn attempts
`define SPAWN_PERIOD 12000

// playfield columns and tile slots
`define NUM_COLS 4
`define NUM_SLOTS 2

`endif

// ==== common/pianoPkg.sv ====
`default_nettype none

package pianoPkg;

	// pixel column, 0..159
	typedef logic [7:0] xCoordT;

	// pixel row, 0..119
	typedef logic [6:0] yCoordT;

	// 3-bit plotter colours
	typedef enum logic [2:0] {
		BLACK  = 3'b000,
		OVER   = 3'b001,
		BORDER = 3'b010,
		BOTTOM = 3'b100,
		TILE   = 3'b111
	} colorT;

	// one of the four playfield columns
	typedef logic [1:0] colIdxT;

	// top level game sequence
	typedef enum logic [1:0] {
		SWEEP_FIELD = 2'd0,
		PLAY        = 2'd1,
		SWEEP_OVER  = 2'd2,
		WAIT_KEY    = 2'd3
	} gamePhaseT;

	// score shown as two hex digits
	typedef logic [7:0] scoreT;

endpackage

`default_nettype wire

// ==== logic/segDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module segDecoder (
	input  wire [3:0]  digit,
	output logic [6:0] segments
);

	// segment order gfedcba, lit when low
	always_comb
	begin
		case (digit)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			default: segments = 7'b0001110;
		endcase
	end

endmodule

`default_nettype wire

// ==== tiles/tileScheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module tileScheduler
	import pianoPkg::*;
(
	input  wire                   CLOCK_50,
	input  wire                   rstN,
	input  wire gamePhaseT        phase,
	input  wire [`NUM_SLOTS-1:0]  slotActive,
	output logic                  shiftTick,
	output logic [`NUM_SLOTS-1:0] spawnStrobe,
	output colIdxT                spawnCol
);

	localparam int SHIFT_W = $clog2(`SHIFT_PERIOD);
	localparam int SPAWN_W = $clog2(`SPAWN_PERIOD);

	logic [SHIFT_W-1:0]    shiftCnt;
	logic [SPAWN_W-1:0]    spawnCnt;
	colIdxT                nextCol;
	logic [`NUM_SLOTS-1:0] freeMask;
	logic                  shiftWrap;
	logic                  spawnWrap;
	logic                  spawnTick;

	assign shiftWrap = (shiftCnt == SHIFT_W'(`SHIFT_PERIOD - 1));
	assign spawnWrap = (spawnCnt == SPAWN_W'(`SPAWN_PERIOD - 1));

	// spawn attempt at count zero, right after entering PLAY
	assign spawnTick = (phase == PLAY) && (spawnCnt == '0);

	// one-hot of the lowest free slot
	always_comb
	begin
		freeMask = '0;
		// walk down so the lowest index wins
		for (int s = `NUM_SLOTS - 1; s >= 0; s--)
		begin
			if (!slotActive[s])
			begin
				freeMask = '0;
				freeMask[s] = 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			shiftCnt    <= '0;
			spawnCnt    <= '0;
			nextCol     <= '0;
			spawnCol    <= '0;
			shiftTick   <= 1'b0;
			spawnStrobe <= '0;
		end
		else if (phase != PLAY)
		begin
			// idle outside PLAY, rotation restarts at column 0
			shiftCnt    <= '0;
			spawnCnt    <= '0;
			nextCol     <= '0;
			shiftTick   <= 1'b0;
			spawnStrobe <= '0;
		end
		else
		begin
			shiftTick <= shiftWrap;
			shiftCnt  <= shiftWrap ? '0 : shiftCnt + 1'b1;
			spawnCnt  <= spawnWrap ? '0 : spawnCnt + 1'b1;

			// no free slot means this tick is skipped
			spawnStrobe <= spawnTick ? freeMask : '0;
			if (spawnTick && (|freeMask))
			begin
				spawnCol <= nextCol;
				nextCol  <= nextCol + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tiles/tileSlot.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module tileSlot
	import pianoPkg::*;
(
	input  wire            CLOCK_50,
	input  wire            rstN,
	input  wire gamePhaseT phase,
	input  wire            shiftTick,
	input  wire            spawnStrobe,
	input  wire colIdxT    spawnCol,
	input  wire            scoredSet,
	output logic           slotActive,
	output logic           slotScored,
	output colIdxT         slotCol,
	output yCoordT         slotBottom,
	output logic           stepStrobe,
	output logic           eraseValid,
	output yCoordT         eraseY,
	output yCoordT         drawY
);

	logic       active;
	logic       scored;
	colIdxT     col;
	yCoordT     top;
	// visible rows, 0..TILE_H
	logic [5:0] height;
	yCoordT     bottomY;
	logic       stepping;
	logic       growStep;
	logic       fallStep;

	// lowest drawn row of the tile
	assign bottomY = top + yCoordT'(height) - 7'd1;

	// a spawn in the same cycle wins over a step
	assign stepping = (phase == PLAY) && active && shiftTick && !spawnStrobe;

	// still sliding in from the top edge
	assign growStep = stepping && (height < 6'(`TILE_H));

	// full height and room for one more row
	assign fallStep = stepping && (height == 6'(`TILE_H))
		&& (bottomY <= 7'(`SCREEN_H - 2));

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			active     <= 1'b0;
			scored     <= 1'b0;
			col        <= '0;
			top        <= '0;
			height     <= '0;
			stepStrobe <= 1'b0;
			eraseValid <= 1'b0;
		end
		else if (phase != PLAY)
		begin
			active     <= 1'b0;
			scored     <= 1'b0;
			top        <= '0;
			height     <= '0;
			stepStrobe <= 1'b0;
			eraseValid <= 1'b0;
		end
		else
		begin
			stepStrobe <= growStep || fallStep;
			if (scoredSet)
				scored <= 1'b1;

			if (spawnStrobe)
			begin
				active <= 1'b1;
				scored <= 1'b0;
				col    <= spawnCol;
				top    <= '0;
				height <= '0;
			end
			else if (growStep)
			begin
				height     <= height + 1'b1;
				eraseValid <= 1'b0;
			end
			else if (fallStep)
			begin
				top        <= top + 1'b1;
				eraseValid <= 1'b1;
			end
			else if (stepping)
			begin
				// reached the bottom line, retire quietly
				active <= 1'b0;
			end
		end
	end

	// row numbers for the painter
	always_ff @(posedge CLOCK_50)
	begin
		if (growStep)
			drawY <= yCoordT'(height);
		else if (fallStep)
		begin
			eraseY <= top;
			drawY  <= bottomY + 7'd1;
		end
	end

	assign slotActive = active;
	assign slotScored = scored;
	assign slotCol    = col;
	// a tile with no rows yet sits above the hit zone
	assign slotBottom = (height == '0) ? '0 : bottomY;

endmodule

`default_nettype wire

// ==== logic/hitJudge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module hitJudge
	import pianoPkg::*;
(
	input  wire                     CLOCK_50,
	input  wire                     rstN,
	input  wire [`NUM_COLS-1:0]     KEY,
	input  wire gamePhaseT          phase,
	input  wire [`NUM_SLOTS-1:0]    slotActive,
	input  wire [`NUM_SLOTS-1:0]    slotScored,
	input  wire colIdxT [`NUM_SLOTS-1:0] slotCol,
	input  wire yCoordT [`NUM_SLOTS-1:0] slotBottom,
	output logic [`NUM_SLOTS-1:0]   scoredSet,
	output logic                    missStrobe,
	output logic                    restartStrobe,
	output scoreT                   score
);

	localparam int CNT_W = $clog2(`NUM_SLOTS + 1);

	// keys are active low, idle high
	logic [`NUM_COLS-1:0]  keySync1;
	logic [`NUM_COLS-1:0]  keySync2;
	logic [`NUM_COLS-1:0]  keyPrev;
	logic [`NUM_COLS-1:0]  keyFall;
	logic [`NUM_COLS-1:0]  colPress;
	logic [`NUM_SLOTS-1:0] hitMask;
	logic [CNT_W-1:0]      hitCount;
	logic                  anyMiss;

	assign keyFall = keyPrev & ~keySync2;

	// KEY[3] is column 0, KEY[0] is column 3
	always_comb
	begin
		for (int c = 0; c < `NUM_COLS; c++)
			colPress[c] = keyFall[`NUM_COLS - 1 - c];
	end

	// judge every pressed column against the slots
	always_comb
	begin
		logic found;
		logic ignored;
		hitMask  = '0;
		hitCount = '0;
		anyMiss  = 1'b0;
		for (int c = 0; c < `NUM_COLS; c++)
		begin
			found   = 1'b0;
			ignored = 1'b0;
			if (colPress[c])
			begin
				for (int s = 0; s < `NUM_SLOTS; s++)
				begin
					if (!found && slotActive[s] && (slotCol[s] == colIdxT'(c))
						&& (slotBottom[s] >= 7'(`HIT_LINE)))
					begin
						// already scored tile swallows the press
						if (slotScored[s])
							ignored = 1'b1;
						else
						begin
							found      = 1'b1;
							hitMask[s] = 1'b1;
							hitCount   = hitCount + 1'b1;
						end
					end
				end
				if (!found && !ignored)
					anyMiss = 1'b1;
			end
		end
	end

	// two-flop synchroniser plus edge history
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			keySync1 <= '1;
			keySync2 <= '1;
			keyPrev  <= '1;
		end
		else
		begin
			keySync1 <= KEY;
			keySync2 <= keySync1;
			keyPrev  <= keySync2;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			score         <= '0;
			scoredSet     <= '0;
			missStrobe    <= 1'b0;
			restartStrobe <= 1'b0;
		end
		else
		begin
			scoredSet     <= '0;
			missStrobe    <= 1'b0;
			restartStrobe <= 1'b0;
			case (phase)
				SWEEP_FIELD: score <= '0;
				PLAY:
				begin
					score      <= score + scoreT'(hitCount);
					scoredSet  <= hitMask;
					missStrobe <= anyMiss;
				end
				// any key restarts after game over
				WAIT_KEY: restartStrobe <= |keyFall;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== painter/screenPainter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module screenPainter
	import pianoPkg::*;
(
	input  wire                     CLOCK_50,
	input  wire                     rstN,
	input  wire                     missStrobe,
	input  wire                     restartStrobe,
	input  wire [`NUM_SLOTS-1:0]    stepStrobe,
	input  wire [`NUM_SLOTS-1:0]    eraseValid,
	input  wire yCoordT [`NUM_SLOTS-1:0] eraseY,
	input  wire yCoordT [`NUM_SLOTS-1:0] drawY,
	input  wire colIdxT [`NUM_SLOTS-1:0] slotCol,
	output gamePhaseT               phase,
	output xCoordT                  vgaX,
	output yCoordT                  vgaY,
	output colorT                   vgaColor,
	output logic                    plot
);

	localparam int SLOT_W = $clog2(`NUM_SLOTS);

	// full-screen sweep position
	xCoordT sweepX;
	yCoordT sweepY;

	// one-deep job store per slot
	logic [`NUM_SLOTS-1:0] pendValid;
	logic [`NUM_SLOTS-1:0] pendErase;
	yCoordT                pendEraseY [`NUM_SLOTS];
	yCoordT                pendDrawY [`NUM_SLOTS];
	colIdxT                pendCol [`NUM_SLOTS];

	// row job in flight
	logic              busy;
	logic              inErase;
	logic [5:0]        pixCnt;
	xCoordT            jobX0;
	yCoordT            jobEraseY;
	yCoordT            jobDrawY;
	logic [SLOT_W-1:0] pickSlot;
	logic              takeJob;

	// border stripes every COL_W + BORDER_W, bottom line on top of them
	function automatic colorT fieldColor(input xCoordT x, input yCoordT y);
		colorT c;
		c = BLACK;
		for (int k = 0; k <= `NUM_COLS; k++)
		begin
			if ((x >= k * (`COL_W + `BORDER_W)) && (x < k * (`COL_W + `BORDER_W) + `BORDER_W))
				c = BORDER;
		end
		if (y == 7'(`SCREEN_H - 1))
			c = BOTTOM;
		return c;
	endfunction

	// left edge of a column
	function automatic xCoordT colStart(input colIdxT c);
		return xCoordT'(`BORDER_W + int'(c) * (`COL_W + `BORDER_W));
	endfunction

	// lowest pending slot first
	always_comb
	begin
		pickSlot = '0;
		for (int s = `NUM_SLOTS - 1; s >= 0; s--)
		begin
			if (pendValid[s])
				pickSlot = SLOT_W'(s);
		end
	end

	assign takeJob = (phase == PLAY) && !missStrobe && !busy && (|pendValid);

	// pending flags, dropped on a miss or outside PLAY
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			pendValid <= '0;
		else if ((phase != PLAY) || missStrobe)
			pendValid <= '0;
		else
		begin
			for (int s = 0; s < `NUM_SLOTS; s++)
			begin
				if (takeJob && (pickSlot == SLOT_W'(s)))
					pendValid[s] <= 1'b0;
				// a new step for the same slot takes priority
				if (stepStrobe[s])
					pendValid[s] <= 1'b1;
			end
		end
	end

	// job contents
	always_ff @(posedge CLOCK_50)
	begin
		for (int s = 0; s < `NUM_SLOTS; s++)
		begin
			if (stepStrobe[s])
			begin
				pendErase[s]  <= eraseValid[s];
				pendEraseY[s] <= eraseY[s];
				pendDrawY[s]  <= drawY[s];
				pendCol[s]    <= slotCol[s];
			end
		end
		if (takeJob)
		begin
			jobX0     <= colStart(pendCol[pickSlot]);
			jobEraseY <= pendEraseY[pickSlot];
			jobDrawY  <= pendDrawY[pickSlot];
		end
	end

	// phase sequencer, sweeps and row engine
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			phase    <= SWEEP_FIELD;
			sweepX   <= '0;
			sweepY   <= '0;
			busy     <= 1'b0;
			inErase  <= 1'b0;
			pixCnt   <= '0;
			plot     <= 1'b0;
			vgaX     <= '0;
			vgaY     <= '0;
			vgaColor <= BLACK;
		end
		else
		begin
			plot <= 1'b0;
			case (phase)
				SWEEP_FIELD, SWEEP_OVER:
				begin
					plot     <= 1'b1;
					vgaX     <= sweepX;
					vgaY     <= sweepY;
					vgaColor <= (phase == SWEEP_OVER) ? OVER : fieldColor(sweepX, sweepY);
					// raster order, x fastest
					if (sweepX == 8'(`SCREEN_W - 1))
					begin
						sweepX <= '0;
						if (sweepY == 7'(`SCREEN_H - 1))
						begin
							sweepY <= '0;
							phase  <= (phase == SWEEP_FIELD) ? PLAY : WAIT_KEY;
						end
						else
							sweepY <= sweepY + 1'b1;
					end
					else
						sweepX <= sweepX + 1'b1;
				end
				PLAY:
				begin
					if (missStrobe)
					begin
						// abandon any row in flight
						phase <= SWEEP_OVER;
						busy  <= 1'b0;
					end
					else if (busy)
					begin
						plot     <= 1'b1;
						vgaX     <= jobX0 + xCoordT'(pixCnt);
						vgaY     <= inErase ? jobEraseY : jobDrawY;
						vgaColor <= inErase ? BLACK : TILE;
						if (pixCnt == 6'(`COL_W - 1))
						begin
							pixCnt <= '0;
							// erase row done, draw row follows
							if (inErase)
								inErase <= 1'b0;
							else
								busy <= 1'b0;
						end
						else
							pixCnt <= pixCnt + 1'b1;
					end
					else if (takeJob)
					begin
						busy    <= 1'b1;
						inErase <= pendErase[pickSlot];
						pixCnt  <= '0;
					end
				end
				WAIT_KEY:
				begin
					if (restartStrobe)
						phase <= SWEEP_FIELD;
				end
				default: phase <= SWEEP_FIELD;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/pianoTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module pianoTop
	import pianoPkg::*;
(
	input  wire              CLOCK_50,
	input  wire              rstN,
	input  wire [3:0]        KEY,
	output xCoordT           vgaX,
	output yCoordT           vgaY,
	output colorT            vgaColor,
	output logic             plot,
	output logic [6:0]       HEX0,
	output logic [6:0]       HEX1
);

	gamePhaseT phase;

	// scheduler to slots
	logic                   shiftTick;
	logic [`NUM_SLOTS-1:0]  spawnStrobe;
	colIdxT                 spawnCol;

	// per-slot status, packed by slot index
	logic [`NUM_SLOTS-1:0]  slotActive;
	logic [`NUM_SLOTS-1:0]  slotScored;
	colIdxT [`NUM_SLOTS-1:0] slotCol;
	yCoordT [`NUM_SLOTS-1:0] slotBottom;

	// per-slot row requests to the painter
	logic [`NUM_SLOTS-1:0]  stepStrobe;
	logic [`NUM_SLOTS-1:0]  eraseValid;
	yCoordT [`NUM_SLOTS-1:0] eraseY;
	yCoordT [`NUM_SLOTS-1:0] drawY;

	// judge outputs
	logic [`NUM_SLOTS-1:0]  scoredSet;
	logic                   missStrobe;
	logic                   restartStrobe;
	scoreT                  score;

	tileScheduler uScheduler (
		.CLOCK_50    (CLOCK_50),
		.rstN        (rstN),
		.phase       (phase),
		.slotActive  (slotActive),
		.shiftTick   (shiftTick),
		.spawnStrobe (spawnStrobe),
		.spawnCol    (spawnCol)
	);

	for (genvar s = 0; s < `NUM_SLOTS; s++)
	begin : gSlot
		tileSlot uSlot (
			.CLOCK_50    (CLOCK_50),
			.rstN        (rstN),
			.phase       (phase),
			.shiftTick   (shiftTick),
			.spawnStrobe (spawnStrobe[s]),
			.spawnCol    (spawnCol),
			.scoredSet   (scoredSet[s]),
			.slotActive  (slotActive[s]),
			.slotScored  (slotScored[s]),
			.slotCol     (slotCol[s]),
			.slotBottom  (slotBottom[s]),
			.stepStrobe  (stepStrobe[s]),
			.eraseValid  (eraseValid[s]),
			.eraseY      (eraseY[s]),
			.drawY       (drawY[s])
		);
	end

	hitJudge uJudge (
		.CLOCK_50      (CLOCK_50),
		.rstN          (rstN),
		.KEY           (KEY),
		.phase         (phase),
		.slotActive    (slotActive),
		.slotScored    (slotScored),
		.slotCol       (slotCol),
		.slotBottom    (slotBottom),
		.scoredSet     (scoredSet),
		.missStrobe    (missStrobe),
		.restartStrobe (restartStrobe),
		.score         (score)
	);

	screenPainter uPainter (
		.CLOCK_50      (CLOCK_50),
		.rstN          (rstN),
		.missStrobe    (missStrobe),
		.restartStrobe (restartStrobe),
		.stepStrobe    (stepStrobe),
		.eraseValid    (eraseValid),
		.eraseY        (eraseY),
		.drawY         (drawY),
		.slotCol       (slotCol),
		.phase         (phase),
		.vgaX          (vgaX),
		.vgaY          (vgaY),
		.vgaColor      (vgaColor),
		.plot          (plot)
	);

	// low nibble on HEX0, high nibble on HEX1
	segDecoder uHex0 (
		.digit    (score[3:0]),
		.segments (HEX0)
	);

	segDecoder uHex1 (
		.digit    (score[7:4]),
		.segments (HEX1)
	);

endmodule

`default_nettype wire

// ==== sim/pianoTests.svh ====
`ifndef PIANO_TESTS_SVH
`define PIANO_TESTS_SVH

// expected tile state per column from the rows seen so far
logic [`NUM_COLS-1:0] tileSeen;
logic [`NUM_COLS-1:0] eraseDone;
int                   tileHeight [`NUM_COLS];
int                   tileTop [`NUM_COLS];

// press the key of one column
// KEY[3] belongs to column 0
task automatic pressKey(input int col, input int holdCycles);
	@(posedge CLOCK_50);
	#2;
	KEY = 4'hF;
	KEY[`NUM_COLS - 1 - col] = 1'b0;
	repeat (holdCycles) @(posedge CLOCK_50);
	#2;
	KEY = 4'hF;
endtask

// check one row job of COL_W pixels against the column model
task automatic takeRow(output colIdxT col, output yCoordT y, output colorT c);
	plotT   first;
	plotT   p;
	int     colNum;
	int     expY;
	colorT  expC;
	xCoordT x0;
	popPixel(first);
	if (first.c == OVER)
		failNow("game over sweep started while the game should still be running");
	colNum = -1;
	for (int k = 0; k < `NUM_COLS; k++)
	begin
		if (int'(first.x) == `BORDER_W + k * (`COL_W + `BORDER_W))
			colNum = k;
	end
	if (colNum < 0)
		failNow($sformatf("row job starts at x 0x%h, not at a column edge", first.x));
	// new tile in this column
	if (!tileSeen[colNum])
	begin
		tileSeen[colNum]   = 1'b1;
		eraseDone[colNum]  = 1'b0;
		tileHeight[colNum] = 0;
		tileTop[colNum]    = 0;
	end
	// grow rows until full height then erase old top and draw new bottom
	if (tileHeight[colNum] < `TILE_H)
	begin
		expY = tileHeight[colNum];
		expC = TILE;
		tileHeight[colNum]++;
	end
	else if (!eraseDone[colNum])
	begin
		expY = tileTop[colNum];
		expC = BLACK;
		eraseDone[colNum] = 1'b1;
	end
	else
	begin
		expY = tileTop[colNum] + `TILE_H;
		expC = TILE;
		tileTop[colNum]++;
		eraseDone[colNum] = 1'b0;
	end
	x0 = xCoordT'(`BORDER_W + colNum * (`COL_W + `BORDER_W));
	checkPixel(x0, yCoordT'(expY), expC, first);
	for (int i = 1; i < `COL_W; i++)
	begin
		popPixel(p);
		checkPixel(x0 + xCoordT'(i), yCoordT'(expY), expC, p);
		if (p.stamp != first.stamp + 32'(i))
			failNow($sformatf("plot dropped inside a row job at pixel %0d", i));
	end
	col = colIdxT'(colNum);
	y   = yCoordT'(expY);
	c   = expC;
endtask

task automatic fieldSweepTest();
	if (plot !== 1'b0)
		failNow("plot is not low right after reset");
	checkScore(8'h00);
	while (pixQ.size() == 0)
		@(negedge CLOCK_50);
	// monitor samples at the edge that closes the first plot cycle
	if (pixQ[0].stamp != releaseCycle + 2)
		failNow($sformatf("field sweep started %0d cycles after reset instead of 1",
			pixQ[0].stamp - releaseCycle - 1));
	checkPhaseSweep(SWEEP_FIELD);
	checkScore(8'h00);
	$display("field sweep checked");
endtask

task automatic tileFallTest();
	colIdxT col;
	yCoordT y;
	colorT  c;
	logic   done;
	int     rows;
	tileSeen  = '0;
	eraseDone = '0;
	done = 1'b0;
	rows = 0;
	// until column 0 draws the last row above the hit line
	while (!done)
	begin
		takeRow(col, y, c);
		if ((rows == 0) && (col != colIdxT'(0)))
			failNow("first tile did not appear in column 0");
		if (col > colIdxT'(1))
			failNow($sformatf("tile row in column %0d before its spawn", col));
		if ((col == colIdxT'(0)) && (c == TILE) && (y == yCoordT'(`HIT_LINE - 1)))
			done = 1'b1;
		rows++;
	end
	if (!tileSeen[1])
		failNow("second tile did not appear in column 1");
	$display("tile fall checked after %0d rows", rows);
endtask

task automatic hitTest();
	colIdxT col;
	yCoordT y;
	colorT  c;
	yCoordT hitY;
	logic   inZone;
	inZone = 1'b0;
	hitY   = '0;
	while (!inZone)
	begin
		takeRow(col, y, c);
		if ((col == colIdxT'(0)) && (c == TILE) && (y >= yCoordT'(`HIT_LINE)))
		begin
			inZone = 1'b1;
			hitY   = y;
		end
	end
	pressKey(0, 8);
	checkScore(8'h01);
	// same tile again while already scored
	pressKey(0, 8);
	repeat (4) @(posedge CLOCK_50);
	checkScore(8'h01);
	// column 0 keeps falling while play goes on
	inZone = 1'b0;
	while (!inZone)
	begin
		takeRow(col, y, c);
		if ((col == colIdxT'(0)) && (c == TILE) && (y >= hitY + 7'd2))
			inZone = 1'b1;
	end
	checkScore(8'h01);
	$display("hit checked");
endtask

task automatic missTest();
	plotT p;
	logic overSeen;
	// column 3 has no tile yet
	pressKey(3, 8);
	overSeen = 1'b0;
	// a row in flight may be cut short by the miss
	while (!overSeen)
	begin
		while (pixQ.size() == 0)
			@(negedge CLOCK_50);
		if (pixQ[0].c == OVER)
			overSeen = 1'b1;
		else
		begin
			popPixel(p);
			if ((p.c != TILE) && (p.c != BLACK))
				failNow($sformatf("unexpected colour 0x%h before the over sweep", p.c));
		end
	end
	checkPhaseSweep(SWEEP_OVER);
	// score holds until the next field sweep
	checkScore(8'h01);
	$display("miss checked");
endtask

task automatic restartTest();
	pressKey(2, 8);
	checkPhaseSweep(SWEEP_FIELD);
	checkScore(8'h00);
	$display("restart checked");
endtask

`endif

// ==== sim/pianoTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pianoParams.svh"

module pianoTb
	import pianoPkg::*;
();

	// one plotted pixel and the edge that sampled it
	typedef struct packed {
		xCoordT      x;
		yCoordT      y;
		colorT       c;
		logic [31:0] stamp;
	} plotT;

	localparam int SWEEP_PIXELS = `SCREEN_W * `SCREEN_H;
	// room for three sweeps and a tile lifetime and a spawn period with margin
	localparam int WATCHDOG_CYCLES = (3 * SWEEP_PIXELS
		+ `SHIFT_PERIOD * (`TILE_H + `SCREEN_H) + `SPAWN_PERIOD) * 5 / 2;

	logic        CLOCK_50;
	logic        rstN;
	logic [3:0]  KEY;
	xCoordT      vgaX;
	yCoordT      vgaY;
	colorT       vgaColor;
	logic        plot;
	logic [6:0]  HEX0;
	logic [6:0]  HEX1;

	logic [31:0] cycleCount = 0;
	logic [31:0] releaseCycle;
	plotT        pixQ[$];

	// active-low gfedcba patterns for 0..F
	logic [6:0] segRef [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	pianoTop dut (
		.CLOCK_50 (CLOCK_50),
		.rstN     (rstN),
		.KEY      (KEY),
		.vgaX     (vgaX),
		.vgaY     (vgaY),
		.vgaColor (vgaColor),
		.plot     (plot),
		.HEX0     (HEX0),
		.HEX1     (HEX1)
	);

	// 40 ns period
	initial
	begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50;
	end

	// every plot goes into the queue
	always @(posedge CLOCK_50)
	begin
		cycleCount = cycleCount + 1;
		if (plot)
			pixQ.push_back('{vgaX, vgaY, vgaColor, cycleCount});
	end

	task automatic failNow(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	// next plotted pixel from the queue
	task automatic popPixel(output plotT p);
		while (pixQ.size() == 0)
			@(negedge CLOCK_50);
		p = pixQ.pop_front();
	endtask

	// bottom line over border stripes every 39 pixels
	function automatic colorT expectedFieldColor(input xCoordT x, input yCoordT y);
		if (y == yCoordT'(`SCREEN_H - 1))
			return BOTTOM;
		if ((int'(x) % (`COL_W + `BORDER_W)) < `BORDER_W)
			return BORDER;
		return BLACK;
	endfunction

	task automatic checkPixel(input xCoordT expX, input yCoordT expY, input colorT expC,
		input plotT got);
		if (got.x !== expX)
			failNow($sformatf("Mismatch vgaX: expected 0x%h, got 0x%h", expX, got.x));
		if (got.y !== expY)
			failNow($sformatf("Mismatch vgaY: expected 0x%h, got 0x%h", expY, got.y));
		if (got.c !== expC)
			failNow($sformatf("Mismatch vgaColor at (0x%h, 0x%h): expected 0x%h, got 0x%h",
				got.x, got.y, expC, got.c));
	endtask

	task automatic checkScore(input scoreT expected);
		logic [6:0] lowRef;
		logic [6:0] highRef;
		lowRef  = segRef[expected[3:0]];
		highRef = segRef[expected[7:4]];
		if (HEX0 !== lowRef)
			failNow($sformatf("Mismatch HEX0: expected 0x%h, got 0x%h", lowRef, HEX0));
		if (HEX1 !== highRef)
			failNow($sformatf("Mismatch HEX1: expected 0x%h, got 0x%h", highRef, HEX1));
	endtask

	// one full-screen sweep in raster order with no gap in plot
	task automatic checkPhaseSweep(input gamePhaseT sweepPhase);
		plotT        p;
		colorT       expC;
		xCoordT      expX;
		yCoordT      expY;
		logic [31:0] prevStamp;
		prevStamp = '0;
		for (int i = 0; i < SWEEP_PIXELS; i++)
		begin
			popPixel(p);
			expX = xCoordT'(i % `SCREEN_W);
			expY = yCoordT'(i / `SCREEN_W);
			expC = (sweepPhase == SWEEP_OVER) ? OVER : expectedFieldColor(expX, expY);
			checkPixel(expX, expY, expC, p);
			if ((i > 0) && (p.stamp != prevStamp + 1))
				failNow($sformatf("plot dropped inside the sweep before pixel %0d", i));
			prevStamp = p.stamp;
		end
	endtask

	`include "pianoTests.svh"

	// watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
		failNow($sformatf("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES));
	end

	initial
	begin
		KEY  = 4'hF;
		rstN = 1'b0;
		repeat (5) @(posedge CLOCK_50);
		#2;
		rstN = 1'b1;
		releaseCycle = cycleCount;
		fieldSweepTest();
		tileFallTest();
		hitTest();
		missTest();
		restartTest();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
+incdir+sim
common/pianoPkg.sv
logic/segDecoder.sv
tiles/tileScheduler.sv
tiles/tileSlot.sv
logic/hitJudge.sv
painter/screenPainter.sv
logic/pianoTop.sv
sim/pianoTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module pianoTb -f build.f -o VpianoTb

# $fatal gives a nonzero exit, the log decides the result
./obj_dir/VpianoTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run FAILED, see sim.log"
	exit 1
fi
grep -q "Simulation completed successfully" sim.log
